// ==== frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

	// address and data widths
	localparam int XLEN      = 32;
	// one line holds two instructions
	localparam int LINE_BITS = 64;
	// memory bus tag width, zero means no tag
	localparam int TAG_BITS  = 4;
	// cache tag kept per line
	localparam int CTAG_BITS = 8;

	////////////////////
	// memory bus command
	////////////////////
	typedef enum logic [1:0] {
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} mem_cmd_t;

	// opcodes seen by predecode
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	////////////////////
	// instruction word views
	////////////////////
	typedef union packed {
		// conditional branch layout
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		// jal layout
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

endpackage

`default_nettype wire

// ==== cache_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_mem import frontend_pkg::*; #(
	parameter int CACHE_LINES = 32
) (
	input  wire                          clock,
	input  wire                          rst_n,
	// refill write port
	input  wire                          wr_en,
	input  wire [$clog2(CACHE_LINES)-1:0] wr_idx,
	input  wire [CTAG_BITS-1:0]          wr_tag,
	input  wire [LINE_BITS-1:0]          wr_data,
	// lookup port
	input  wire [$clog2(CACHE_LINES)-1:0] rd_idx,
	input  wire [CTAG_BITS-1:0]          rd_tag,
	output logic [LINE_BITS-1:0]         rd_data,
	output logic                         rd_valid
);

	// line storage
	logic [LINE_BITS-1:0] data_q  [CACHE_LINES];
	logic [CTAG_BITS-1:0] tag_q   [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;

	////////////////////
	// lookup
	////////////////////

	// combinational read, same cycle as the index
	assign rd_data  = data_q[rd_idx];
	// hit needs a live line and the same tag
	assign rd_valid = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

	////////////////////
	// refill
	////////////////////

	// valid bits, cleared on reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// data and tag words
	always_ff @(posedge clock) begin
		if (wr_en) begin
			data_q[wr_idx] <= wr_data;
			tag_q[wr_idx]  <= wr_tag;
		end
	end

	// refill index must be known when written
	a_wr_idx_known: assert property (@(posedge clock) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_idx));

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache import frontend_pkg::*; #(
	parameter int CACHE_LINES = 32
) (
	input  wire                           clock,
	input  wire                           rst_n,
	// fetch side
	input  wire  [XLEN-1:0]               fetch_addr,
	input  wire                           fetch_en,
	output logic                          hit,
	output logic [LINE_BITS-1:0]          hit_line,
	// memory bus
	output mem_cmd_t                      proc2mem_command,
	output logic [XLEN-1:0]               proc2mem_addr,
	input  wire  [TAG_BITS-1:0]           mem2proc_response,
	input  wire  [LINE_BITS-1:0]          mem2proc_data,
	input  wire  [TAG_BITS-1:0]           mem2proc_tag,
	// line storage lookup
	output logic [$clog2(CACHE_LINES)-1:0] rd_idx,
	output logic [CTAG_BITS-1:0]          rd_tag,
	input  wire  [LINE_BITS-1:0]          rd_data,
	input  wire                           rd_valid,
	// line storage refill
	output logic                          wr_en,
	output logic [$clog2(CACHE_LINES)-1:0] wr_idx,
	output logic [CTAG_BITS-1:0]          wr_tag,
	output logic [LINE_BITS-1:0]          wr_data
);

	localparam int IDX_BITS = $clog2(CACHE_LINES);

	// outstanding request state
	logic                 pending_q;
	logic [TAG_BITS-1:0]  pend_tag_q;
	logic [IDX_BITS-1:0]  miss_idx_q;
	logic [CTAG_BITS-1:0] miss_tag_q;

	logic miss;
	logic issue;
	logic accepted;
	logic refill;

	////////////////////
	// address split
	////////////////////

	// byte offset is bits 2:0, index above it, tag above that
	assign rd_idx = fetch_addr[3 +: IDX_BITS];
	assign rd_tag = fetch_addr[3 + IDX_BITS +: CTAG_BITS];

	// hit goes straight back to fetch
	assign hit      = fetch_en && rd_valid;
	assign hit_line = rd_data;
	assign miss     = fetch_en && !rd_valid;

	////////////////////
	// request issue
	////////////////////

	// one request in flight at most
	// a rejected one is simply reissued next cycle
	assign issue    = miss && !pending_q;
	assign accepted = issue && (mem2proc_response != '0);

	assign proc2mem_command = issue ? BUS_LOAD : BUS_NONE;
	// line aligned
	assign proc2mem_addr    = {fetch_addr[XLEN-1:3], 3'b000};

	// returned tag matches the one we were given
	assign refill = pending_q && (mem2proc_tag == pend_tag_q);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pending_q  <= 1'b0;
			pend_tag_q <= '0;
		end else if (accepted) begin
			pending_q  <= 1'b1;
			pend_tag_q <= mem2proc_response;
		end else if (refill) begin
			pending_q  <= 1'b0;
			pend_tag_q <= '0;
		end
	end

	// where the line goes once it returns
	// kept even if fetch has moved on after a redirect
	always_ff @(posedge clock) begin
		if (accepted) begin
			miss_idx_q <= rd_idx;
			miss_tag_q <= rd_tag;
		end
	end

	////////////////////
	// refill write
	////////////////////

	assign wr_en   = refill;
	assign wr_idx  = miss_idx_q;
	assign wr_tag  = miss_tag_q;
	assign wr_data = mem2proc_data;

	// once accepted, the bus stays quiet until the line is back
	a_one_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
		(proc2mem_command == BUS_LOAD && mem2proc_response != '0)
			|=> (proc2mem_command == BUS_NONE));

endmodule

`default_nettype wire

// ==== branch_pred.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_pred import frontend_pkg::*; #(
	parameter int BP_ENTRIES = 64
) (
	input  wire             clock,
	input  wire             rst_n,
	// lookup for the pc being fetched
	input  wire [XLEN-1:0]  pred_pc,
	output logic            pred_taken,
	// update from the back end
	input  wire             resolve,
	input  wire [XLEN-1:0]  resolve_pc,
	input  wire             resolve_taken
);

	localparam int BP_IDX = $clog2(BP_ENTRIES);

	// two-bit counters, msb is the guess
	logic [1:0] cnt_q [BP_ENTRIES];

	logic [BP_IDX-1:0] pred_idx;
	logic [BP_IDX-1:0] res_idx;

	// word address, low bits only
	assign pred_idx = pred_pc[2 +: BP_IDX];
	assign res_idx  = resolve_pc[2 +: BP_IDX];

	assign pred_taken = cnt_q[pred_idx][1];

	////////////////////
	// counter update
	////////////////////

	// all counters start weakly not-taken
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BP_ENTRIES; i++) begin
				cnt_q[i] <= 2'b01;
			end
		end else if (resolve) begin
			// step toward the outcome, stop at the ends
			if (resolve_taken) begin
				if (cnt_q[res_idx] != 2'b11) begin
					cnt_q[res_idx] <= cnt_q[res_idx] + 2'b01;
				end
			end else begin
				if (cnt_q[res_idx] != 2'b00) begin
					cnt_q[res_idx] <= cnt_q[res_idx] - 2'b01;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_stage import frontend_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  wire                  clock,
	input  wire                  rst_n,
	// back end control
	input  wire                  stall,
	input  wire                  redirect,
	input  wire  [XLEN-1:0]      redirect_pc,
	// cache
	output logic [XLEN-1:0]      fetch_addr,
	output logic                 fetch_en,
	input  wire                  hit,
	input  wire  [LINE_BITS-1:0] hit_line,
	// predictor
	output logic [XLEN-1:0]      pred_pc,
	input  wire                  pred_taken,
	// packet to the back end
	output logic                 fetch_valid,
	output logic [XLEN-1:0]      fetch_pc,
	output logic [31:0]          fetch_inst,
	output logic                 fetch_pred_taken,
	output logic [XLEN-1:0]      fetch_next_pc
);

	logic [XLEN-1:0] pc_q;
	// low for the first cycle out of reset
	logic            run_q;

	inst_t           inst;
	logic            is_jal;
	logic            is_br;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] j_imm;
	logic [XLEN-1:0] next_pc;
	logic            taken;
	logic            take;

	assign fetch_addr = pc_q;
	assign pred_pc    = pc_q;
	// no lookup while held or being steered away
	assign fetch_en   = run_q && !stall && !redirect;

	////////////////////
	// predecode
	////////////////////

	// pc bit 2 picks the half of the line
	assign inst   = pc_q[2] ? hit_line[63:32] : hit_line[31:0];
	assign is_jal = (inst.j.opcode == OPC_JAL);
	assign is_br  = (inst.b.opcode == OPC_BRANCH);

	// sign extended, bit 0 always zero
	assign b_imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	assign j_imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
		inst.j.imm11, inst.j.imm10_1, 1'b0};

	// jal always leaves, a branch only on the counter
	assign taken   = is_jal || (is_br && pred_taken);
	assign next_pc = is_jal ? (pc_q + j_imm) :
		(is_br && pred_taken) ? (pc_q + b_imm) : (pc_q + 32'd4);

	// packet only on a clean hit
	assign take = hit && !stall && !redirect;

	////////////////////
	// pc register
	////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc_q  <= RESET_PC;
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			// redirect wins over everything
			if (redirect) begin
				pc_q <= redirect_pc;
			end else if (take) begin
				pc_q <= next_pc;
			end
		end
	end

	////////////////////
	// packet register
	////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			fetch_pc         <= pc_q;
			fetch_inst       <= inst;
			fetch_pred_taken <= taken;
			fetch_next_pc    <= next_pc;
		end
	end

	// a redirect leaves a bubble
	a_redirect_bubble: assert property (@(posedge clock) disable iff (!rst_n)
		redirect |=> !fetch_valid);

endmodule

`default_nettype wire

// ==== frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module frontend import frontend_pkg::*; #(
	parameter int              CACHE_LINES = 32,
	parameter int              BP_ENTRIES  = 64,
	parameter logic [XLEN-1:0] RESET_PC    = '0
) (
	input  wire                  clock,
	input  wire                  rst_n,
	// back end feedback
	input  wire                  stall,
	input  wire                  redirect,
	input  wire  [XLEN-1:0]      redirect_pc,
	input  wire                  resolve,
	input  wire  [XLEN-1:0]      resolve_pc,
	input  wire                  resolve_taken,
	// memory bus
	output mem_cmd_t             proc2mem_command,
	output logic [XLEN-1:0]      proc2mem_addr,
	input  wire  [TAG_BITS-1:0]  mem2proc_response,
	input  wire  [LINE_BITS-1:0] mem2proc_data,
	input  wire  [TAG_BITS-1:0]  mem2proc_tag,
	// fetch packet
	output logic                 fetch_valid,
	output logic [XLEN-1:0]      fetch_pc,
	output logic [31:0]          fetch_inst,
	output logic                 fetch_pred_taken,
	output logic [XLEN-1:0]      fetch_next_pc
);

	localparam int IDX_BITS = $clog2(CACHE_LINES);

	////////////////////
	// fetch to cache
	////////////////////
	logic [XLEN-1:0]      fetch_addr;
	logic                 fetch_en;
	logic                 hit;
	logic [LINE_BITS-1:0] hit_line;

	// cache controller to line storage
	logic [IDX_BITS-1:0]  rd_idx;
	logic [CTAG_BITS-1:0] rd_tag;
	logic [LINE_BITS-1:0] rd_data;
	logic                 rd_valid;
	logic                 wr_en;
	logic [IDX_BITS-1:0]  wr_idx;
	logic [CTAG_BITS-1:0] wr_tag;
	logic [LINE_BITS-1:0] wr_data;

	// fetch to predictor
	logic [XLEN-1:0]      pred_pc;
	logic                 pred_taken;

	if_stage #(.RESET_PC(RESET_PC)) u_if_stage (
		.clock, .rst_n, .stall, .redirect, .redirect_pc,
		.fetch_addr, .fetch_en, .hit, .hit_line,
		.pred_pc, .pred_taken,
		.fetch_valid, .fetch_pc, .fetch_inst, .fetch_pred_taken, .fetch_next_pc
	);

	icache #(.CACHE_LINES(CACHE_LINES)) u_icache (
		.clock, .rst_n, .fetch_addr, .fetch_en, .hit, .hit_line,
		.proc2mem_command, .proc2mem_addr,
		.mem2proc_response, .mem2proc_data, .mem2proc_tag,
		.rd_idx, .rd_tag, .rd_data, .rd_valid,
		.wr_en, .wr_idx, .wr_tag, .wr_data
	);

	// line storage sits beside the controller
	cache_mem #(.CACHE_LINES(CACHE_LINES)) u_cache_mem (
		.clock, .rst_n, .wr_en, .wr_idx, .wr_tag, .wr_data,
		.rd_idx, .rd_tag, .rd_data, .rd_valid
	);

	// resolve comes straight from the back end
	branch_pred #(.BP_ENTRIES(BP_ENTRIES)) u_branch_pred (
		.clock, .rst_n, .pred_pc, .pred_taken,
		.resolve, .resolve_pc, .resolve_taken
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_NS = 5
) (
	output logic clock
);

	// free running, 10 ns period
	initial clock = 1'b0;
	always #HALF_NS clock = ~clock;

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import frontend_pkg::*; #(
	parameter logic [31:0] SEED = 32'hbf0cbd11
) (
	input  wire                  clock,
	input  wire                  rst_n,
	input  mem_cmd_t             proc2mem_command,
	input  wire  [XLEN-1:0]      proc2mem_addr,
	output logic [TAG_BITS-1:0]  mem2proc_response,
	output logic [LINE_BITS-1:0] mem2proc_data,
	output logic [TAG_BITS-1:0]  mem2proc_tag,
	// line written into the cache at the coming edge
	output logic                 fill_valid,
	output logic [XLEN-1:0]      fill_addr
);

	// program image of 4 KB words
	logic [31:0] mem [1024];

	integer seed = SEED;
	logic        accept_ok = 1'b0;
	logic        busy = 1'b0;
	logic [3:0]  cur_tag = 4'd0;
	logic [3:0]  next_tag = 4'd1;
	logic [31:0] req_addr = 32'd0;
	int          wait_cnt = 0;
	logic        accepted;
	logic        rst_s;
	logic [31:0] addr_s;

	// answered in the same cycle and zero means rejected
	assign mem2proc_response = (proc2mem_command == BUS_LOAD && accept_ok && !busy) ?
		next_tag : 4'd0;

	initial begin
		mem2proc_data = '0;
		mem2proc_tag  = '0;
		fill_valid    = 1'b0;
		fill_addr     = '0;
	end

	////////////////////
	// request and return
	////////////////////
	always @(posedge clock) begin
		// sample the bus before the edge settles
		rst_s    = rst_n;
		accepted = rst_s && proc2mem_command == BUS_LOAD && mem2proc_response != 4'd0;
		addr_s   = proc2mem_addr;
		#1;
		mem2proc_tag = 4'd0;
		fill_valid   = 1'b0;
		if (!rst_s) begin
			busy      = 1'b0;
			next_tag  = 4'd1;
			accept_ok = 1'b0;
		end else begin
			// count down the line in flight
			if (busy) begin
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					mem2proc_tag  = cur_tag;
					mem2proc_data = {mem[{req_addr[11:3], 1'b1}], mem[{req_addr[11:3], 1'b0}]};
					fill_valid    = 1'b1;
					fill_addr     = req_addr;
					busy          = 1'b0;
				end
			end
			if (accepted) begin
				busy     = 1'b1;
				cur_tag  = next_tag;
				req_addr = addr_s;
				// 2 to 9 cycles
				wait_cnt = ($random(seed) & 7) + 2;
				// tags run 1..15
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// three in four requests accepted
			accept_ok = (($random(seed) & 3) != 0);
		end
	end

endmodule

`default_nettype wire

// ==== tb_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_frontend import frontend_pkg::*;;

	localparam logic [31:0] RESET_PC = 32'd0;
	localparam int EXP_PACKETS = 1300;
	localparam int LIMIT = 200 * EXP_PACKETS + 16;

	logic clock;
	logic rst_n = 1'b0;
	logic stall = 1'b0;
	logic redirect = 1'b0;
	logic [31:0] redirect_pc = 32'd0;
	logic resolve = 1'b0;
	logic [31:0] resolve_pc = 32'd0;
	logic resolve_taken = 1'b0;

	mem_cmd_t    cmd;
	logic [31:0] maddr;
	logic [3:0]  resp;
	logic [3:0]  rtag;
	logic [63:0] rdata;
	logic        fill_valid;
	logic [31:0] fill_addr;
	logic        fetch_valid;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_inst;
	logic        fetch_pred_taken;
	logic [31:0] fetch_next_pc;

	// reference state
	integer seed = 32'hbf0cbd11;
	logic [31:0] img [1024];
	logic [1:0]  cnt [64];
	logic        cv [32];
	logic [7:0]  ct [32];
	logic [31:0] hist [16];
	logic [31:0] exp_pc = RESET_PC;
	logic        exp_pkt = 1'b0;
	logic        prev_red = 1'b0;
	logic        prev_stall = 1'b0;
	int errors = 0;
	int checks = 0;
	int pkts = 0;
	int cycles = 0;

	tb_clock_gen u_clock_gen (.clock);

	tb_mem_model #(.SEED(32'hbf0cbd11)) u_mem_model (
		.clock, .rst_n, .proc2mem_command(cmd), .proc2mem_addr(maddr),
		.mem2proc_response(resp), .mem2proc_data(rdata), .mem2proc_tag(rtag),
		.fill_valid, .fill_addr
	);

	frontend #(.CACHE_LINES(32), .BP_ENTRIES(64), .RESET_PC(RESET_PC)) u_frontend (
		.clock, .rst_n, .stall, .redirect, .redirect_pc,
		.resolve, .resolve_pc, .resolve_taken,
		.proc2mem_command(cmd), .proc2mem_addr(maddr),
		.mem2proc_response(resp), .mem2proc_data(rdata), .mem2proc_tag(rtag),
		.fetch_valid, .fetch_pc, .fetch_inst, .fetch_pred_taken, .fetch_next_pc
	);

	// bus requests and the cache contents they bring in
	always @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				cv[i] = 1'b0;
			end
		end else begin
			// a request asks for the line of the pc being fetched
			if (cmd == BUS_LOAD) begin
				if (u_mem_model.busy) begin
					errors = errors + 1;
					$display("error at %0t: request issued while one is in flight", $time);
				end
				check_value(maddr, {exp_pc[31:3], 3'b000}, "proc2mem_addr");
			end
			if (fill_valid) begin
				cv[fill_addr[7:3]] = 1'b1;
				ct[fill_addr[7:3]] = fill_addr[15:8];
			end
		end
	end

	// run limit
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout: run stopped after %0d cycles with %0d packets", cycles, pkts);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////
	// program image
	////////////////////
	function automatic logic [31:0] enc_jal(input int off, input logic [4:0] rd);
		logic [20:0] im;
		im = off[20:0];
		return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_br(input int off, input logic [31:0] r);
		logic [12:0] im;
		im = off[12:0];
		return {im[12], im[10:5], r[24:20], r[19:15], r[14:12], im[4:1], im[11], 7'b1100011};
	endfunction

	task automatic build_image();
		logic [31:0] w;
		logic [31:0] sel;
		int off;
		for (int i = 0; i < 1024; i++) begin
			w = $random(seed);
			// plain words must not decode as control flow
			if (w[6:0] == 7'b1101111 || w[6:0] == 7'b1100011) begin
				w[2] = ~w[2];
			end
			sel = $random(seed);
			if (sel[2:0] == 3'd0) begin
				off = (int'(sel[7:3]) + 1) * 4;
				if (sel[13]) begin
					off = -off;
				end
				// stay inside the image
				if (i * 4 + off < 0 || i * 4 + off > 4092) begin
					off = -off;
				end
				w = sel[14] ? enc_jal(off, w[11:7]) : enc_br(off, w);
			end
			// last word wraps back to the start
			if (i == 1023) begin
				w = enc_jal(-4092, 5'd1);
			end
			img[i] = w;
			u_mem_model.mem[i] = w;
		end
	endtask

	// next-pc rule on the image word
	task automatic predict(input logic [31:0] pc, input logic [31:0] w,
		output logic pt, output logic [31:0] nxt);
		logic [31:0] jimm;
		logic [31:0] bimm;
		jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		pt  = 1'b0;
		nxt = pc + 32'd4;
		if (w[6:0] == 7'b1101111) begin
			pt  = 1'b1;
			nxt = pc + jimm;
		end else if (w[6:0] == 7'b1100011 && cnt[pc[7:2]][1]) begin
			pt  = 1'b1;
			nxt = pc + bimm;
		end
	endtask

	function automatic logic cache_holds(input logic [31:0] pc);
		return cv[pc[7:3]] && ct[pc[7:3]] == pc[15:8];
	endfunction

	////////////////////
	// one cycle checks the packet and then drives
	////////////////////
	task automatic run_cycle(input logic st, input logic rd, input logic [31:0] rpc,
		input logic rs, input logic [31:0] rspc, input logic rtk);
		logic [31:0] w;
		logic [31:0] nxt;
		logic pt;
		@(posedge clock);
		#1;
		if (fetch_valid) begin
			if (prev_red) begin
				errors = errors + 1;
				$display("error at %0t: packet in the cycle after a redirect", $time);
			end
			if (prev_stall) begin
				errors = errors + 1;
				$display("error at %0t: packet in the cycle after a stall", $time);
			end
			w = img[exp_pc[11:2]];
			predict(exp_pc, w, pt, nxt);
			check_value(fetch_pc, exp_pc, "fetch_pc");
			check_value(fetch_inst, w, "fetch_inst");
			check_value({31'd0, fetch_pred_taken}, {31'd0, pt}, "fetch_pred_taken");
			check_value(fetch_next_pc, nxt, "fetch_next_pc");
			hist[pkts % 16] = exp_pc;
			exp_pc = nxt;
			pkts = pkts + 1;
		end else if (exp_pkt) begin
			errors = errors + 1;
			$display("error at %0t: no packet for cached pc %h", $time, exp_pc);
		end
		// a cached line with nothing in the way must give a packet
		exp_pkt = !st && !rd && cache_holds(exp_pc);
		stall = st;
		redirect = rd;
		redirect_pc = rpc;
		resolve = rs;
		resolve_pc = rspc;
		resolve_taken = rtk;
		if (rd) begin
			exp_pc = rpc;
		end
		if (rs) begin
			if (rtk && cnt[rspc[7:2]] != 2'b11) begin
				cnt[rspc[7:2]] = cnt[rspc[7:2]] + 2'b01;
			end else if (!rtk && cnt[rspc[7:2]] != 2'b00) begin
				cnt[rspc[7:2]] = cnt[rspc[7:2]] - 2'b01;
			end
		end
		prev_red = rd;
		prev_stall = st;
	endtask

	task automatic run_packets(input int n);
		int target;
		target = pkts + n;
		while (pkts < target) begin
			run_cycle(1'b0, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
		end
	endtask

	// stalled cycles with random predictor training
	task automatic train_stalled(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			run_cycle(1'b1, 1'b0, 32'd0, r[0], {20'd0, r[11:2], 2'b00}, r[1]);
		end
	endtask

	task automatic report(input string name, input int err0);
		$display("%s: done at packet %0d, %0d errors", name, pkts, errors - err0);
	endtask

	initial begin
		int err0;
		int stall_left;
		logic [31:0] r;
		for (int i = 0; i < 64; i++) begin
			cnt[i] = 2'b01;
		end
		for (int i = 0; i < 32; i++) begin
			cv[i] = 1'b0;
			ct[i] = 8'd0;
		end
		build_image();
		repeat (16) @(posedge clock);
		#1;
		rst_n = 1'b1;

		// cold start across random miss latency
		err0 = errors;
		run_packets(300);
		report("cold fetch", err0);

		// back into lines already fetched
		err0 = errors;
		for (int k = 0; k < 10; k++) begin
			r = $random(seed);
			run_cycle(1'b0, 1'b1, hist[r[3:0]], 1'b0, 32'd0, 1'b0);
			run_packets(30);
		end
		report("warm redirect", err0);

		// train counters and then run branches and jumps
		err0 = errors;
		train_stalled(40);
		run_packets(300);
		report("jump and branch prediction", err0);

		// random redirects and stall windows
		err0 = errors;
		stall_left = 0;
		while (pkts < EXP_PACKETS) begin
			r = $random(seed);
			if (stall_left > 0) begin
				train_stalled(1);
				stall_left = stall_left - 1;
			end else if (r[3:0] == 4'd0) begin
				run_cycle(1'b0, 1'b1, {20'd0, r[17:8], 2'b00}, 1'b0, 32'd0, 1'b0);
			end else begin
				if (r[6:4] == 3'd0) begin
					stall_left = int'(r[20:18]) + 1;
				end
				run_cycle(1'b0, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
			end
		end
		run_cycle(1'b0, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
		report("redirect and stall mix", err0);

		$display("packets %0d, checks %0d, errors %0d", pkts, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== frontend.f ====
frontend_pkg.sv
cache_mem.sv
icache.sv
branch_pred.sv
if_stage.sv
frontend.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_frontend.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_frontend -f frontend.f \
	--Mdir obj_dir -o tb_frontend_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_frontend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
